//--- common/scdb_cfg_pkg.sv
// secondary buffer sizing: channel count, data widths and buffer depths
package scdb_cfg_pkg;

  // channel side
  localparam int N_CHAN          = 4;
  localparam int CHANS_PER_CYCLE = 2;
  localparam int CHAN_W          = 2;
  localparam int DATA_W          = 16;

  // shared sample memory
  localparam int BUF_WORDS = 32;
  localparam int ADDR_W    = 5;

  // waveform length is stored as words minus one
  localparam int LEN_W = 4;

  // header fifo
  localparam int HDR_DEPTH = 4;
  localparam int HDR_PTR_W = 2;
  localparam int HDR_CNT_W = 3;

  // words used, 0 to BUF_WORDS inclusive
  localparam int OCC_W = 6;

endpackage

//--- common/scdb_ctrl_pkg.sv
// secondary buffer control encodings for the finder, writer and reader FSMs
package scdb_ctrl_pkg;

  typedef enum logic [0:0] {
    fnd_scan,
    fnd_offer
  } finder_state_e;

  typedef enum logic [2:0] {
    wr_idle,
    wr_take_hdr,
    wr_wait_room,
    wr_copy,
    wr_finish
  } writer_state_e;

  typedef enum logic [1:0] {
    rd_idle,
    rd_hdr_read,
    rd_stream
  } reader_state_e;

endpackage

//--- src/chan_finder.sv
// channel finder: round-robin search for the next channel holding a waveform
`timescale 1ns/1ns

module chan_finder
  import scdb_cfg_pkg::*;
  import scdb_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic [N_CHAN-1:0] i_wvb_hdr_empty,
  input  logic              i_grant_ready,
  output logic              o_grant_valid,
  output logic [CHAN_W-1:0] o_grant_chan
);

  finder_state_e state;
  logic [CHAN_W-1:0] base;
  logic [CHANS_PER_CYCLE-1:0][CHAN_W-1:0] q_chan;
  logic [CHANS_PER_CYCLE-1:0] q_ready;
  logic q_valid;
  logic hit;
  logic [CHAN_W-1:0] hit_chan;

  // first queried channel with a waveform wins
  always_comb begin
    hit = 1'b0;
    hit_chan = '0;
    for (int i = 0; i < CHANS_PER_CYCLE; i++) begin
      if (!hit && q_ready[i]) begin
        hit = 1'b1;
        hit_chan = q_chan[i];
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= fnd_scan;
      base <= '0;
      q_chan <= '0;
      q_ready <= '0;
      q_valid <= 1'b0;
      o_grant_valid <= 1'b0;
      o_grant_chan <= '0;
    end else begin
      case (state)
        fnd_scan: begin
          for (int i = 0; i < CHANS_PER_CYCLE; i++) begin
            q_chan[i] <= base + CHAN_W'(i);
            q_ready[i] <= !i_wvb_hdr_empty[base + CHAN_W'(i)];
          end
          q_valid <= 1'b1;
          base <= base + CHAN_W'(CHANS_PER_CYCLE);
          if (q_valid && hit) begin
            o_grant_valid <= 1'b1;
            o_grant_chan <= hit_chan;
            state <= fnd_offer;
          end
        end
        fnd_offer: begin
          // restart just after the granted channel, old samples are stale
          if (i_grant_ready) begin
            o_grant_valid <= 1'b0;
            base <= o_grant_chan + 1'b1;
            q_valid <= 1'b0;
            state <= fnd_scan;
          end
        end
        default: begin
          state <= fnd_scan;
        end
      endcase
    end
  end

endmodule

//--- scdb_writer/scdb_writer.sv
// secondary buffer writer: copies one channel waveform into the shared memory
`timescale 1ns/1ns

module scdb_writer
  import scdb_cfg_pkg::*;
  import scdb_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_grant_valid,
  input  logic [CHAN_W-1:0]        i_grant_chan,
  input  logic [N_CHAN*LEN_W-1:0]  i_wvb_len,
  input  logic [N_CHAN*DATA_W-1:0] i_wvb_data,
  input  logic                     i_hdr_full,
  input  logic                     i_rel_valid,
  input  logic [LEN_W-1:0]         i_rel_len,
  output logic                     o_grant_ready,
  output logic [N_CHAN-1:0]        o_wvb_hdr_rdreq,
  output logic [N_CHAN-1:0]        o_wvb_rdreq,
  output logic                     o_ram_we,
  output logic [ADDR_W-1:0]        o_ram_waddr,
  output logic [DATA_W-1:0]        o_ram_wdata,
  output logic                     o_hdr_push,
  output logic [CHAN_W-1:0]        o_hdr_chan,
  output logic [ADDR_W-1:0]        o_hdr_start,
  output logic [LEN_W-1:0]         o_hdr_len,
  output logic [OCC_W-1:0]         o_words_used
);

  writer_state_e state;
  logic [CHAN_W-1:0] chan;
  logic [LEN_W-1:0]  len;
  logic [LEN_W-1:0]  rd_cnt;
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] start;
  logic [N_CHAN-1:0] chan_sel;
  logic [OCC_W-1:0]  rel_words;
  logic              take;
  logic              room;

  assign o_grant_ready = (state == wr_idle);
  assign take = o_grant_ready && i_grant_valid;
  assign chan_sel = N_CHAN'(1) << chan;
  assign rel_words = i_rel_valid ? OCC_W'(i_rel_len) + OCC_W'(1) : '0;

  // whole waveform must fit, plus a free header slot
  assign room = !i_hdr_full &&
                (o_words_used + OCC_W'(len) + OCC_W'(1) <= OCC_W'(BUF_WORDS));

  assign o_ram_waddr = wr_ptr;
  assign o_ram_wdata = i_wvb_data[chan*DATA_W +: DATA_W];
  assign o_hdr_chan  = chan;
  assign o_hdr_start = start;
  assign o_hdr_len   = len;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= wr_idle;
      o_wvb_hdr_rdreq <= '0;
      o_wvb_rdreq <= '0;
      o_ram_we <= 1'b0;
      o_hdr_push <= 1'b0;
      rd_cnt <= '0;
      wr_ptr <= '0;
      o_words_used <= '0;
    end else begin
      o_wvb_hdr_rdreq <= '0;
      o_hdr_push <= 1'b0;
      // sample shows up the cycle after its request
      o_ram_we <= |o_wvb_rdreq;
      if (o_ram_we) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      o_words_used <= o_words_used + OCC_W'(o_ram_we) - rel_words;

      case (state)
        wr_idle: begin
          if (take) begin
            o_wvb_hdr_rdreq <= N_CHAN'(1) << i_grant_chan;
            state <= wr_take_hdr;
          end
        end
        wr_take_hdr: begin
          state <= wr_wait_room;
        end
        wr_wait_room: begin
          if (room) begin
            o_wvb_rdreq <= chan_sel;
            rd_cnt <= '0;
            state <= wr_copy;
          end
        end
        wr_copy: begin
          if (rd_cnt == len) begin
            o_wvb_rdreq <= '0;
            state <= wr_finish;
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        wr_finish: begin
          // last write lands this cycle
          o_hdr_push <= 1'b1;
          state <= wr_idle;
        end
        default: begin
          state <= wr_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      chan <= i_grant_chan;
      len <= i_wvb_len[i_grant_chan*LEN_W +: LEN_W];
    end
    if (state == wr_wait_room && room) begin
      start <= wr_ptr;
    end
  end

endmodule

//--- scdb_reader/scdb_reader.sv
// secondary buffer reader: pops headers and streams waveforms out
`timescale 1ns/1ns

module scdb_reader
  import scdb_cfg_pkg::*;
  import scdb_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              i_arst_n,
  input  logic              i_hdr_empty,
  input  logic [CHAN_W-1:0] i_hdr_q_chan,
  input  logic [ADDR_W-1:0] i_hdr_q_start,
  input  logic [LEN_W-1:0]  i_hdr_q_len,
  input  logic [DATA_W-1:0] i_ram_rdata,
  input  logic              i_out_ready,
  output logic              o_hdr_pop,
  output logic [ADDR_W-1:0] o_ram_raddr,
  output logic              o_out_valid,
  output logic [DATA_W-1:0] o_out_data,
  output logic [CHAN_W-1:0] o_out_chan,
  output logic              o_out_last,
  output logic              o_rel_valid,
  output logic [LEN_W-1:0]  o_rel_len
);

  reader_state_e state;
  logic [ADDR_W-1:0] rd_addr;
  logic [LEN_W-1:0]  rd_left;
  logic              rd_pend;
  logic              load;
  logic              more;
  logic              last_xfer;
  logic [CHAN_W-1:0] chan;
  logic [LEN_W-1:0]  len;
  logic [LEN_W-1:0]  out_len;

  assign more = (rd_left != '0);
  // rdata holds the word at rd_addr while rd_pend is set
  assign load = rd_pend && (!o_out_valid || i_out_ready);
  assign last_xfer = o_out_valid && i_out_ready && o_out_last;
  // read ahead so the next word follows without a gap
  assign o_ram_raddr = (load && more) ? rd_addr + 1'b1 : rd_addr;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= rd_idle;
      o_hdr_pop <= 1'b0;
      o_out_valid <= 1'b0;
      o_rel_valid <= 1'b0;
      rd_pend <= 1'b0;
      rd_addr <= '0;
      rd_left <= '0;
    end else begin
      o_hdr_pop <= 1'b0;
      o_rel_valid <= last_xfer;
      if (load) begin
        o_out_valid <= 1'b1;
      end else if (i_out_ready) begin
        o_out_valid <= 1'b0;
      end

      case (state)
        rd_idle: begin
          if (!i_hdr_empty) begin
            rd_addr <= i_hdr_q_start;
            rd_left <= i_hdr_q_len;
            o_hdr_pop <= 1'b1;
            state <= rd_hdr_read;
          end
        end
        rd_hdr_read: begin
          rd_pend <= 1'b1;
          state <= rd_stream;
        end
        rd_stream: begin
          if (load && more) begin
            rd_addr <= rd_addr + 1'b1;
            rd_left <= rd_left - 1'b1;
          end else if (load) begin
            rd_pend <= 1'b0;
            state <= rd_idle;
          end
        end
        default: begin
          state <= rd_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rd_idle && !i_hdr_empty) begin
      chan <= i_hdr_q_chan;
      len <= i_hdr_q_len;
    end
    if (load) begin
      o_out_data <= i_ram_rdata;
      o_out_chan <= chan;
      o_out_last <= !more;
      if (!more) begin
        out_len <= len;
      end
    end
    if (last_xfer) begin
      o_rel_len <= out_len;
    end
  end

endmodule

//--- src/scdb_store.sv
// secondary buffer storage: shared sample memory and header FIFO
`timescale 1ns/1ns

module scdb_store
  import scdb_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_ram_we,
  input  logic [ADDR_W-1:0]    i_ram_waddr,
  input  logic [DATA_W-1:0]    i_ram_wdata,
  input  logic [ADDR_W-1:0]    i_ram_raddr,
  input  logic                 i_hdr_push,
  input  logic [CHAN_W-1:0]    i_hdr_chan,
  input  logic [ADDR_W-1:0]    i_hdr_start,
  input  logic [LEN_W-1:0]     i_hdr_len,
  input  logic                 i_hdr_pop,
  output logic [DATA_W-1:0]    o_ram_rdata,
  output logic                 o_hdr_empty,
  output logic                 o_hdr_full,
  output logic [CHAN_W-1:0]    o_hdr_q_chan,
  output logic [ADDR_W-1:0]    o_hdr_q_start,
  output logic [LEN_W-1:0]     o_hdr_q_len,
  output logic [HDR_CNT_W-1:0] o_wfm_count
);

  logic [DATA_W-1:0] mem [BUF_WORDS];
  logic [CHAN_W-1:0] hq_chan [HDR_DEPTH];
  logic [ADDR_W-1:0] hq_start [HDR_DEPTH];
  logic [LEN_W-1:0]  hq_len [HDR_DEPTH];
  logic [HDR_PTR_W-1:0] wptr;
  logic [HDR_PTR_W-1:0] rptr;
  logic [HDR_CNT_W-1:0] count;
  logic do_push;
  logic do_pop;

  // simple dual port, registered read
  always_ff @(posedge clk) begin
    if (i_ram_we) begin
      mem[i_ram_waddr] <= i_ram_wdata;
    end
    o_ram_rdata <= mem[i_ram_raddr];
  end

  assign o_hdr_empty = (count == '0);
  assign o_hdr_full = (count == HDR_CNT_W'(HDR_DEPTH));
  assign do_push = i_hdr_push && !o_hdr_full;
  assign do_pop = i_hdr_pop && !o_hdr_empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      hq_chan[wptr] <= i_hdr_chan;
      hq_start[wptr] <= i_hdr_start;
      hq_len[wptr] <= i_hdr_len;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wptr <= '0;
      rptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wptr <= wptr + 1'b1;
      end
      if (do_pop) begin
        rptr <= rptr + 1'b1;
      end
      count <= count + HDR_CNT_W'(do_push) - HDR_CNT_W'(do_pop);
    end
  end

  // head entry visible without a read request
  assign o_hdr_q_chan = hq_chan[rptr];
  assign o_hdr_q_start = hq_start[rptr];
  assign o_hdr_q_len = hq_len[rptr];
  assign o_wfm_count = count;

endmodule

//--- src/secondary_buffer.sv
// secondary waveform buffer: moves channel waveforms into a shared memory and out
`timescale 1ns/1ns

module secondary_buffer
  import scdb_cfg_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic [N_CHAN-1:0]        i_wvb_hdr_empty,
  input  logic [N_CHAN*LEN_W-1:0]  i_wvb_len,
  input  logic [N_CHAN*DATA_W-1:0] i_wvb_data,
  output logic [N_CHAN-1:0]        o_wvb_hdr_rdreq,
  output logic [N_CHAN-1:0]        o_wvb_rdreq,
  input  logic                     i_out_ready,
  output logic                     o_out_valid,
  output logic [DATA_W-1:0]        o_out_data,
  output logic [CHAN_W-1:0]        o_out_chan,
  output logic                     o_out_last,
  output logic [OCC_W-1:0]         o_words_used,
  output logic [HDR_CNT_W-1:0]     o_wfm_count
);

  logic              grant_valid;
  logic              grant_ready;
  logic [CHAN_W-1:0] grant_chan;
  logic              ram_we;
  logic [ADDR_W-1:0] ram_waddr;
  logic [DATA_W-1:0] ram_wdata;
  logic [ADDR_W-1:0] ram_raddr;
  logic [DATA_W-1:0] ram_rdata;
  logic              hdr_push;
  logic [CHAN_W-1:0] hdr_chan;
  logic [ADDR_W-1:0] hdr_start;
  logic [LEN_W-1:0]  hdr_len;
  logic              hdr_full;
  logic              hdr_empty;
  logic              hdr_pop;
  logic [CHAN_W-1:0] hdr_q_chan;
  logic [ADDR_W-1:0] hdr_q_start;
  logic [LEN_W-1:0]  hdr_q_len;
  logic              rel_valid;
  logic [LEN_W-1:0]  rel_len;

  chan_finder i_chan_finder (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_wvb_hdr_empty (i_wvb_hdr_empty),
    .i_grant_ready   (grant_ready),
    .o_grant_valid   (grant_valid),
    .o_grant_chan    (grant_chan)
  );

  scdb_writer i_scdb_writer (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_grant_valid   (grant_valid),
    .i_grant_chan    (grant_chan),
    .i_wvb_len       (i_wvb_len),
    .i_wvb_data      (i_wvb_data),
    .i_hdr_full      (hdr_full),
    .i_rel_valid     (rel_valid),
    .i_rel_len       (rel_len),
    .o_grant_ready   (grant_ready),
    .o_wvb_hdr_rdreq (o_wvb_hdr_rdreq),
    .o_wvb_rdreq     (o_wvb_rdreq),
    .o_ram_we        (ram_we),
    .o_ram_waddr     (ram_waddr),
    .o_ram_wdata     (ram_wdata),
    .o_hdr_push      (hdr_push),
    .o_hdr_chan      (hdr_chan),
    .o_hdr_start     (hdr_start),
    .o_hdr_len       (hdr_len),
    .o_words_used    (o_words_used)
  );

  scdb_store i_scdb_store (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_ram_we      (ram_we),
    .i_ram_waddr   (ram_waddr),
    .i_ram_wdata   (ram_wdata),
    .i_ram_raddr   (ram_raddr),
    .i_hdr_push    (hdr_push),
    .i_hdr_chan    (hdr_chan),
    .i_hdr_start   (hdr_start),
    .i_hdr_len     (hdr_len),
    .i_hdr_pop     (hdr_pop),
    .o_ram_rdata   (ram_rdata),
    .o_hdr_empty   (hdr_empty),
    .o_hdr_full    (hdr_full),
    .o_hdr_q_chan  (hdr_q_chan),
    .o_hdr_q_start (hdr_q_start),
    .o_hdr_q_len   (hdr_q_len),
    .o_wfm_count   (o_wfm_count)
  );

  scdb_reader i_scdb_reader (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_hdr_empty   (hdr_empty),
    .i_hdr_q_chan  (hdr_q_chan),
    .i_hdr_q_start (hdr_q_start),
    .i_hdr_q_len   (hdr_q_len),
    .i_ram_rdata   (ram_rdata),
    .i_out_ready   (i_out_ready),
    .o_hdr_pop     (hdr_pop),
    .o_ram_raddr   (ram_raddr),
    .o_out_valid   (o_out_valid),
    .o_out_data    (o_out_data),
    .o_out_chan    (o_out_chan),
    .o_out_last    (o_out_last),
    .o_rel_valid   (rel_valid),
    .o_rel_len     (rel_len)
  );

endmodule

//--- tb/tb_clk_gen.sv
// testbench clock and reset source, 100 ns period with reset held for 4 cycles
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk,
  output logic o_arst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    o_arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #5;
    o_arst_n = 1'b1;
  end

endmodule

//--- tb/scdb_checker.sv
// output stream checker comparing every transfer with the expected waveforms
`timescale 1ns/1ns

module scdb_checker
  import scdb_cfg_pkg::*;
(
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_valid,
  input  logic                 i_ready,
  input  logic [DATA_W-1:0]    i_data,
  input  logic [CHAN_W-1:0]    i_chan,
  input  logic                 i_last,
  input  logic [OCC_W-1:0]     i_words_used,
  input  logic [HDR_CNT_W-1:0] i_wfm_count,
  input  logic [N_CHAN-1:0]    i_wvb_rdreq,
  input  logic [N_CHAN-1:0]    i_wvb_hdr_rdreq,
  output logic                 o_done,
  output int                   o_tests_run,
  output int                   o_tests_failed,
  output int                   o_check_errors
);

  localparam int VEC_DEPTH = 256;
  localparam int MAX_WFM   = 16;
  localparam int MAX_WORDS = 128;

  logic [15:0]       vec [VEC_DEPTH];
  logic [DATA_W-1:0] exp_data [MAX_WORDS];
  logic [CHAN_W-1:0] exp_chan [MAX_WORDS];
  logic              exp_last [MAX_WORDS];
  int                exp_wfm [MAX_WORDS];
  int                total;
  int                idx;
  logic              wfm_bad;
  logic              reset_bad;

  // flatten the waveforms into the order they must leave the buffer
  task automatic build_expected();
    int wchan [MAX_WFM];
    int wlen [MAX_WFM];
    int wpos [MAX_WFM];
    logic used [MAX_WFM];
    int n;
    int pos;
    int pick;
    $readmemh("tb/scdb_vectors.txt", vec);
    n = int'(vec[0]);
    pos = 1;
    for (int w = 0; w < n; w++) begin
      wchan[w] = int'(vec[pos]);
      wlen[w] = int'(vec[pos+1]);
      wpos[w] = pos + 2;
      used[w] = 1'b0;
      pos = pos + 2 + wlen[w];
    end
    total = 0;
    for (int k = 0; k < n; k++) begin
      pick = -1;
      for (int w = 0; w < n; w++) begin
        if (pick < 0 && !used[w] && wchan[w] == int'(vec[pos+k])) begin
          pick = w;
        end
      end
      if (pick >= 0) begin
        used[pick] = 1'b1;
        for (int j = 0; j < wlen[pick]; j++) begin
          exp_data[total] = vec[wpos[pick]+j];
          exp_chan[total] = CHAN_W'(wchan[pick]);
          exp_last[total] = (j == wlen[pick] - 1);
          exp_wfm[total] = pick;
          total++;
        end
      end
    end
  endtask

  task automatic check_zero(input string what, input int actual);
    if (actual != 0) begin
      $display("** Error reset_values: %s expected 0 actual %0d", what, actual);
      reset_bad = 1'b1;
    end
  endtask

  initial begin
    o_tests_run = 0;
    o_tests_failed = 0;
    o_check_errors = 0;
    idx = 0;
    wfm_bad = 1'b0;
    reset_bad = 1'b0;
    build_expected();
    @(negedge clk);
    check_zero("out_valid", int'(i_valid));
    check_zero("wvb_rdreq", int'(i_wvb_rdreq));
    check_zero("wvb_hdr_rdreq", int'(i_wvb_hdr_rdreq));
    check_zero("words_used", int'(i_words_used));
    check_zero("wfm_count", int'(i_wfm_count));
    o_tests_run++;
    if (reset_bad) begin
      o_tests_failed++;
    end
    $display("test reset_values: %s", reset_bad ? "FAILED" : "ok");
  end

  assign o_done = (total > 0) && (idx == total);

  // compare each accepted word at the falling edge
  always @(negedge clk) begin
    if (i_arst_n) begin
      if (i_words_used > OCC_W'(BUF_WORDS) || i_wfm_count > HDR_CNT_W'(HDR_DEPTH)) begin
        $display("occupancy over limit: %0d words, %0d waveforms", i_words_used,
                 i_wfm_count);
        o_check_errors++;
      end
      if (i_valid && i_ready) begin
        if (idx >= total) begin
          $display("extra word on the output stream, data %h", i_data);
          o_check_errors++;
        end else begin
          if (i_data !== exp_data[idx]) begin
            $display("** Error wfm%0d_ch%0d: data expected %h actual %h", exp_wfm[idx],
                     exp_chan[idx], exp_data[idx], i_data);
            wfm_bad = 1'b1;
          end
          if (i_chan !== exp_chan[idx]) begin
            $display("** Error wfm%0d_ch%0d: chan expected %0d actual %0d", exp_wfm[idx],
                     exp_chan[idx], exp_chan[idx], i_chan);
            wfm_bad = 1'b1;
          end
          if (i_last !== exp_last[idx]) begin
            $display("** Error wfm%0d_ch%0d: last expected %0b actual %0b", exp_wfm[idx],
                     exp_chan[idx], exp_last[idx], i_last);
            wfm_bad = 1'b1;
          end
          if (exp_last[idx]) begin
            o_tests_run++;
            if (wfm_bad) begin
              o_tests_failed++;
            end
            $display("test wfm%0d_ch%0d: %s", exp_wfm[idx], exp_chan[idx],
                     wfm_bad ? "FAILED" : "ok");
            wfm_bad = 1'b0;
          end
          idx++;
        end
      end
    end
  end

endmodule

//--- tb/scdb_assert.sv
// handshake and occupancy assertions for the reader and writer
`timescale 1ns/1ns

module scdb_assert
  import scdb_cfg_pkg::*;
(
  input logic                     clk,
  input logic                     i_arst_n,
  input logic                     i_valid,
  input logic                     i_ready,
  input logic [DATA_W+CHAN_W:0]   i_payload,
  input logic [OCC_W-1:0]         i_level,
  input logic                     i_limit_ok,
  input logic [N_CHAN-1:0]        i_onehot
);

  // stalled output keeps valid and payload
  a_stall_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_valid && !i_ready |=> i_valid && $stable(i_payload))
    else $error("output changed while stalled");

  a_level: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_level <= OCC_W'(BUF_WORDS))
    else $error("words used above memory depth");

  a_limit: assert property (@(posedge clk) disable iff (!i_arst_n) i_limit_ok)
    else $error("header fifo pushed while full or popped while empty");

  a_onehot: assert property (@(posedge clk) disable iff (!i_arst_n) $onehot0(i_onehot))
    else $error("channel read request not one-hot");

endmodule

bind scdb_reader scdb_assert i_reader_assert (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_valid    (o_out_valid),
  .i_ready    (i_out_ready),
  .i_payload  ({o_out_last, o_out_chan, o_out_data}),
  .i_level    ('0),
  .i_limit_ok (!(o_hdr_pop && i_hdr_empty)),
  .i_onehot   ('0)
);

bind scdb_writer scdb_assert i_writer_assert (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_valid    (1'b0),
  .i_ready    (1'b1),
  .i_payload  ('0),
  .i_level    (o_words_used),
  .i_limit_ok (!(o_hdr_push && i_hdr_full)),
  .i_onehot   (o_wvb_rdreq)
);

//--- tb/tb_secondary_buffer.sv
// testbench top with the channel buffer models, vector loading and output stimulus
`timescale 1ns/1ns

module tb_secondary_buffer
  import scdb_cfg_pkg::*;
();

  localparam int VEC_DEPTH  = 256;
  localparam int SAMP_DEPTH = 64;
  localparam int HDR_SLOTS  = 8;

  logic                     clk;
  logic                     i_arst_n;
  logic [N_CHAN-1:0]        i_wvb_hdr_empty;
  logic [N_CHAN*LEN_W-1:0]  i_wvb_len;
  logic [N_CHAN*DATA_W-1:0] i_wvb_data;
  logic [N_CHAN-1:0]        o_wvb_hdr_rdreq;
  logic [N_CHAN-1:0]        o_wvb_rdreq;
  logic                     i_out_ready;
  logic                     o_out_valid;
  logic [DATA_W-1:0]        o_out_data;
  logic [CHAN_W-1:0]        o_out_chan;
  logic                     o_out_last;
  logic [OCC_W-1:0]         o_words_used;
  logic [HDR_CNT_W-1:0]     o_wfm_count;
  logic                     done;
  int                       tests_run;
  int                       tests_failed;
  int                       check_errors;

  logic [15:0]       vec [VEC_DEPTH];
  logic [DATA_W-1:0] samp_mem [N_CHAN][SAMP_DEPTH];
  logic [LEN_W-1:0]  hdr_mem [N_CHAN][HDR_SLOTS];
  int                samp_rd [N_CHAN];
  int                samp_wr [N_CHAN];
  int                hdr_rd [N_CHAN];
  int                hdr_wr [N_CHAN];
  logic [N_CHAN-1:0] prev_rdreq;
  logic [N_CHAN-1:0] prev_hdr_rdreq;
  integer            seed;
  logic [31:0]       rnd;
  int                cycles;
  logic              timed_out;
  logic              stuck;

  tb_clk_gen i_tb_clk_gen (.clk(clk), .o_arst_n(i_arst_n));

  secondary_buffer i_secondary_buffer (.*);

  scdb_checker i_scdb_checker (
    .clk (clk), .i_arst_n (i_arst_n), .i_valid (o_out_valid), .i_ready (i_out_ready),
    .i_data (o_out_data), .i_chan (o_out_chan), .i_last (o_out_last),
    .i_words_used (o_words_used), .i_wfm_count (o_wfm_count),
    .i_wvb_rdreq (o_wvb_rdreq), .i_wvb_hdr_rdreq (o_wvb_hdr_rdreq),
    .o_done (done), .o_tests_run (tests_run), .o_tests_failed (tests_failed),
    .o_check_errors (check_errors)
  );

  // fill the channel models from the vector file
  task automatic load_channels();
    int pos;
    int c;
    int len;
    $readmemh("tb/scdb_vectors.txt", vec);
    pos = 1;
    for (int w = 0; w < int'(vec[0]); w++) begin
      c = int'(vec[pos]);
      len = int'(vec[pos+1]);
      hdr_mem[c][hdr_wr[c]] = LEN_W'(len - 1);
      hdr_wr[c]++;
      for (int j = 0; j < len; j++) begin
        samp_mem[c][samp_wr[c]] = vec[pos+2+j];
        samp_wr[c]++;
      end
      pos = pos + 2 + len;
    end
  endtask

  task automatic drive_headers();
    for (int c = 0; c < N_CHAN; c++) begin
      i_wvb_hdr_empty[c] = (hdr_rd[c] == hdr_wr[c]);
      i_wvb_len[c*LEN_W +: LEN_W] = (hdr_rd[c] < HDR_SLOTS) ? hdr_mem[c][hdr_rd[c]] : '0;
    end
  endtask

  // requests seen in the last cycle are answered now
  always @(posedge clk) begin
    #5;
    for (int c = 0; c < N_CHAN; c++) begin
      if (prev_rdreq[c] && samp_rd[c] < samp_wr[c]) begin
        i_wvb_data[c*DATA_W +: DATA_W] = samp_mem[c][samp_rd[c]];
        samp_rd[c]++;
      end
      if (prev_hdr_rdreq[c] && hdr_rd[c] < hdr_wr[c]) begin
        hdr_rd[c]++;
      end
    end
    prev_rdreq = o_wvb_rdreq;
    prev_hdr_rdreq = o_wvb_hdr_rdreq;
    drive_headers();
  end

  initial begin
    seed = 32'h5745;
    i_out_ready = 1'b0;
    i_wvb_data = '0;
    prev_rdreq = '0;
    prev_hdr_rdreq = '0;
    timed_out = 1'b0;
    stuck = 1'b0;
    for (int c = 0; c < N_CHAN; c++) begin
      samp_rd[c] = 0;
      samp_wr[c] = 0;
      hdr_rd[c] = 0;
      hdr_wr[c] = 0;
    end
    load_channels();
    drive_headers();

    cycles = 0;
    while (!i_arst_n && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (!i_arst_n) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end

    // output blocked so the memory fills up
    repeat (150) @(posedge clk);

    cycles = 0;
    while (!timed_out && !done && cycles < 5000) begin
      @(posedge clk);
      #5;
      rnd = $random(seed);
      i_out_ready = rnd[0];
      cycles++;
    end
    if (!done) begin
      $display("timeout waiting for the output stream to finish");
      timed_out = 1'b1;
    end

    cycles = 0;
    while (!timed_out && o_words_used != '0 && cycles < 50) begin
      @(posedge clk);
      #5;
      cycles++;
    end
    if (o_words_used != '0) begin
      $display("** Error drain: words_used expected 0 actual %0d", o_words_used);
      stuck = 1'b1;
    end
    if (o_wfm_count != '0) begin
      $display("** Error drain: wfm_count expected 0 actual %0d", o_wfm_count);
      stuck = 1'b1;
    end

    $display("tests run %0d, failed %0d, other errors %0d", tests_run, tests_failed,
             check_errors + int'(stuck) + int'(timed_out));
    if (!timed_out && !stuck && tests_failed == 0 && check_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb/scdb_vectors.txt
// first word: waveform count; then per waveform: channel, word count, samples
// last line: expected output order by channel
8
0 4 0a00 0a01 0a02 0a03
1 6 1b00 1b01 1b02 1b03 1b04 1b05
2 10 2c00 2c01 2c02 2c03 2c04 2c05 2c06 2c07
2c08 2c09 2c0a 2c0b 2c0c 2c0d 2c0e 2c0f
3 2 3d00 3d01
0 8 0e00 0e01 0e02 0e03 0e04 0e05 0e06 0e07
1 5 1f00 1f01 1f02 1f03 1f04
3 7 3a00 3a01 3a02 3a03 3a04 3a05 3a06
0 3 0b00 0b01 0b02
0 1 2 3 0 1 3 0

//--- tb.f
common/scdb_cfg_pkg.sv
common/scdb_ctrl_pkg.sv
src/chan_finder.sv
scdb_writer/scdb_writer.sv
scdb_reader/scdb_reader.sv
src/scdb_store.sv
src/secondary_buffer.sv
tb/tb_clk_gen.sv
tb/scdb_checker.sv
tb/scdb_assert.sv
tb/tb_secondary_buffer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the secondary buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_secondary_buffer -Mdir obj_dir -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "result: fail"; exit 1; } \
  || { echo "result: pass"; exit 0; }
